//--- ft_tx_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module ft_tx_fsm (
   input  wire   ft_clkout_i,
   input  wire   rst_n,
   input  wire   empty_i,
   input  wire   active_i,
   input  wire   flush_en_i,
   input  wire   ft_txe_n_i,
   input  wire   ft_suspend_n_i,
   output logic  pop_o,
   output logic  ft_wr_n_o,
   output logic  ft_siwua_n_o,
   output logic  busy_o
);

   usb_stream_pkg::tx_state_e state_q;
   usb_stream_pkg::tx_state_e state_d;
   logic                      suspend_n_q;

   // Single register stage on the suspend pin
   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         suspend_n_q <= 1'b0;
      end else begin
         suspend_n_q <= ft_suspend_n_i;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         usb_stream_pkg::TX_IDLE: begin
            if (active_i || !empty_i) begin
               state_d = usb_stream_pkg::TX_STREAM;
            end
         end
         usb_stream_pkg::TX_STREAM: begin
            // Burst done once the source is idle and the FIFO drained
            if (!active_i && empty_i) begin
               if (flush_en_i) begin
                  state_d = usb_stream_pkg::TX_FLUSH;
               end else begin
                  state_d = usb_stream_pkg::TX_IDLE;
               end
            end
         end
         default: begin
            state_d = usb_stream_pkg::TX_IDLE;
         end
      endcase
   end

   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         state_q <= usb_stream_pkg::TX_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Strobe is gated by registered terms only and never by txe
   assign ft_wr_n_o = !((state_q == usb_stream_pkg::TX_STREAM) && !empty_i && suspend_n_q);

   // A byte leaves the FIFO exactly on an accepted edge
   assign pop_o = !ft_wr_n_o && !ft_txe_n_i;

   // Send immediate lasts the one cycle spent in TX_FLUSH
   assign ft_siwua_n_o = (state_q != usb_stream_pkg::TX_FLUSH);

   assign busy_o = !empty_i || (state_q != usb_stream_pkg::TX_IDLE);

   // Send immediate only once the whole burst has left the FIFO
   siwua_after_drain: assert property (
      @(posedge ft_clkout_i) disable iff (!rst_n)
      !ft_siwua_n_o |-> (empty_i && !active_i)
   );

endmodule

`default_nettype wire

//--- pattern_counter.sv
`default_nettype none
`timescale 1ns/10ps

module pattern_counter (
   input  wire                                ft_clkout_i,
   input  wire                                rst_n,
   input  wire                                start_i,
   input  wire [usb_stream_pkg::DATA_W-1:0]   start_val_i,
   input  wire [usb_stream_pkg::LEN_W-1:0]    len_i,
   input  wire                                full_i,
   output logic                               push_o,
   output logic [usb_stream_pkg::DATA_W-1:0]  push_data_o,
   output logic                               active_o
);

   logic [usb_stream_pkg::DATA_W-1:0] value_q;
   logic [usb_stream_pkg::LEN_W-1:0]  remain_q;

   assign active_o    = (remain_q != '0);
   // One byte per cycle whenever the FIFO has room
   assign push_o      = active_o && !full_i;
   assign push_data_o = value_q;

   // Bytes left in the current burst
   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         remain_q <= '0;
      end else if (start_i) begin
         remain_q <= len_i;
      end else if (push_o) begin
         remain_q <= remain_q - 1'b1;
      end
   end

   // Next pattern byte wraps naturally at 8 bits
   always_ff @(posedge ft_clkout_i) begin
      if (start_i) begin
         value_q <= start_val_i;
      end else if (push_o) begin
         value_q <= value_q + 1'b1;
      end
   end

   // A new burst never lands on one still running
   start_only_when_idle: assert property (
      @(posedge ft_clkout_i) disable iff (!rst_n)
      start_i |-> !active_o
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the USB stream testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f src.f --top-module tb_usb_stream \
   --Mdir obj_dir -o sim_usb_stream

# The simulator exits nonzero on a failure, the log decides the result
./obj_dir/sim_usb_stream 2>&1 | tee sim.log || true

if grep -q "Test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- src.f
usb_stream_pkg.sv
wb_stream_regs.sv
pattern_counter.sv
tx_fifo.sv
ft_tx_fsm.sv
usb_stream_top.sv
tb_usb_stream.sv

//--- tb_usb_stream.sv
`default_nettype none
`timescale 1ns/10ps

module tb_usb_stream;

   // Roughly 300 bytes at up to 4 cycles each plus register traffic and wide margin
   localparam int MAX_CYCLES = 20000;
   localparam int WB_ACK_LIMIT = 8;
   localparam int TXE_READY = 0;
   localparam int TXE_HOLD = 1;
   localparam int TXE_RANDOM = 2;

   logic                                ft_clkout_i;
   logic                                rst_n;
   logic                                wb_cyc_i;
   logic                                wb_stb_i;
   logic                                wb_we_i;
   logic [1:0]                          wb_adr_i;
   logic [usb_stream_pkg::WB_DW-1:0]    wb_dat_i;
   wire  [usb_stream_pkg::WB_DW-1:0]    wb_dat_o;
   wire                                 wb_ack_o;
   wire  [usb_stream_pkg::DATA_W-1:0]   ft_data_o;
   wire                                 ft_wr_n_o;
   wire                                 ft_siwua_n_o;
   logic                                ft_txe_n_i;
   logic                                ft_suspend_n_i;

   // FT2232H model state
   logic [usb_stream_pkg::DATA_W-1:0]   rx_q[$];
   int                                  siwua_count;
   int                                  siwua_cycle;
   int                                  last_accept_cycle;
   int                                  cycle_count;
   int                                  txe_mode;
   logic                                susp_prev;

   usb_stream_top uut (
      .ft_clkout_i    (ft_clkout_i),
      .rst_n          (rst_n),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .ft_data_o      (ft_data_o),
      .ft_wr_n_o      (ft_wr_n_o),
      .ft_siwua_n_o   (ft_siwua_n_o),
      .ft_txe_n_i     (ft_txe_n_i),
      .ft_suspend_n_i (ft_suspend_n_i)
   );

   initial begin
      ft_clkout_i = 1'b0;
      forever #50 ft_clkout_i = ~ft_clkout_i;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic compare_byte(input string name,
                               input logic [usb_stream_pkg::DATA_W-1:0] act,
                               input logic [usb_stream_pkg::DATA_W-1:0] exp);
      if (act !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
         report_failure("Byte compare failed");
      end
   endtask

   task automatic compare_word(input string name,
                               input logic [usb_stream_pkg::WB_DW-1:0] act,
                               input logic [usb_stream_pkg::WB_DW-1:0] exp);
      if (act !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
         report_failure("Word compare failed");
      end
   endtask

   task automatic compare_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
         report_failure("Bit compare failed");
      end
   endtask

   // Transmit-ready pin follows the selected mode
   initial begin
      void'($urandom(32'h9084_11d0));
      ft_txe_n_i = 1'b1;
      forever begin
         @(negedge ft_clkout_i);
         case (txe_mode)
            TXE_READY: ft_txe_n_i = 1'b0;
            TXE_HOLD:  ft_txe_n_i = 1'b1;
            default:   ft_txe_n_i = (($urandom % 3) == 0);
         endcase
      end
   end

   // Write side of the FT2232H plus the run cycle counter
   always @(posedge ft_clkout_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         report_failure("Run exceeded the cycle limit without finishing");
      end
      if (rst_n) begin
         if (!ft_wr_n_o && !ft_txe_n_i) begin
            if (!susp_prev) begin
               report_failure("A byte was accepted while suspend was low");
            end
            rx_q.push_back(ft_data_o);
            last_accept_cycle = cycle_count;
         end
         if (!ft_siwua_n_o) begin
            siwua_count = siwua_count + 1;
            siwua_cycle = cycle_count;
         end
      end
      // Suspend as seen by the writer one edge later
      susp_prev = rst_n ? ft_suspend_n_i : 1'b0;
   end

   task automatic wb_write(input usb_stream_pkg::wb_addr_e addr,
                           input logic [usb_stream_pkg::WB_DW-1:0] data);
      int waited;
      waited = 0;
      @(negedge ft_clkout_i);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b1;
      wb_adr_i = addr;
      wb_dat_i = data;
      do begin
         @(negedge ft_clkout_i);
         waited++;
         if (waited > WB_ACK_LIMIT) begin
            report_failure("Wishbone write received no ack");
         end
      end while (!wb_ack_o);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wb_read(input usb_stream_pkg::wb_addr_e addr,
                          output logic [usb_stream_pkg::WB_DW-1:0] data);
      int waited;
      waited = 0;
      @(negedge ft_clkout_i);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b0;
      wb_adr_i = addr;
      do begin
         @(negedge ft_clkout_i);
         waited++;
         if (waited > WB_ACK_LIMIT) begin
            report_failure("Wishbone read received no ack");
         end
      end while (!wb_ack_o);
      data = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic check_reg(input usb_stream_pkg::wb_addr_e addr, input string name,
                            input logic [usb_stream_pkg::WB_DW-1:0] exp);
      logic [usb_stream_pkg::WB_DW-1:0] data;
      wb_read(addr, data);
      compare_word(name, data, exp);
   endtask

   task automatic wait_idle(input int max_reads);
      logic [usb_stream_pkg::WB_DW-1:0] status;
      int reads;
      reads = 0;
      do begin
         wb_read(usb_stream_pkg::REG_STATUS, status);
         reads++;
         if (reads > max_reads) begin
            report_failure("Busy flag did not clear in time");
         end
      end while (status[0]);
   endtask

   task automatic wait_rx_count(input int n, input int max_cycles);
      int waited;
      waited = 0;
      while (rx_q.size() < n) begin
         @(negedge ft_clkout_i);
         waited++;
         if (waited > max_cycles) begin
            report_failure("Expected bytes did not arrive in time");
         end
      end
   endtask

   task automatic clear_model();
      rx_q.delete();
      siwua_count = 0;
      siwua_cycle = 0;
      last_accept_cycle = 0;
   endtask

   task automatic start_burst(input logic [usb_stream_pkg::DATA_W-1:0] start_val,
                              input int len, input logic flush);
      wb_write(usb_stream_pkg::REG_START, start_val);
      wb_write(usb_stream_pkg::REG_LEN, len);
      wb_write(usb_stream_pkg::REG_CTRL, {30'd0, flush, 1'b1});
   endtask

   // Sequence must be start, start+1, ... modulo 256 with nothing extra
   task automatic check_burst(input logic [usb_stream_pkg::DATA_W-1:0] start_val,
                              input int len);
      logic [usb_stream_pkg::DATA_W-1:0] exp;
      exp = start_val;
      compare_word("rx_count", rx_q.size(), len);
      for (int i = 0; i < len; i++) begin
         compare_byte("ft_data_o", rx_q[i], exp);
         exp = exp + 8'h01;
      end
   endtask

   task automatic test_reset_and_regs();
      compare_bit("ft_wr_n_o", ft_wr_n_o, 1'b1);
      compare_bit("ft_siwua_n_o", ft_siwua_n_o, 1'b1);
      check_reg(usb_stream_pkg::REG_START, "start_val", 32'h0);
      check_reg(usb_stream_pkg::REG_LEN, "len", 32'h0);
      check_reg(usb_stream_pkg::REG_STATUS, "status", 32'h0);
      wb_write(usb_stream_pkg::REG_START, 32'h0000_005A);
      wb_write(usb_stream_pkg::REG_LEN, 32'h0000_1234);
      wb_write(usb_stream_pkg::REG_CTRL, 32'h0000_0002);
      check_reg(usb_stream_pkg::REG_START, "start_val", 32'h0000_005A);
      check_reg(usb_stream_pkg::REG_LEN, "len", 32'h0000_1234);
      check_reg(usb_stream_pkg::REG_CTRL, "ctrl", 32'h0000_0002);
      wb_write(usb_stream_pkg::REG_CTRL, 32'h0);
      check_reg(usb_stream_pkg::REG_CTRL, "ctrl", 32'h0);
   endtask

   task automatic test_wrap_burst();
      clear_model();
      txe_mode = TXE_READY;
      start_burst(8'hF0, 40, 1'b0);
      wait_idle(200);
      check_burst(8'hF0, 40);
      compare_word("siwua_count", siwua_count, 0);
   endtask

   task automatic test_random_txe_suspend();
      clear_model();
      txe_mode = TXE_RANDOM;
      start_burst(8'h11, 200, 1'b0);
      wait_rx_count(60, 1000);
      @(negedge ft_clkout_i);
      ft_suspend_n_i = 1'b0;
      repeat (6) @(negedge ft_clkout_i);
      ft_suspend_n_i = 1'b1;
      wait_idle(1000);
      check_burst(8'h11, 200);
   endtask

   task automatic test_flush();
      clear_model();
      txe_mode = TXE_READY;
      start_burst(8'hA0, 10, 1'b1);
      wait_idle(200);
      check_burst(8'hA0, 10);
      compare_word("siwua_count", siwua_count, 1);
      compare_bit("siwua_after_last_byte", siwua_cycle > last_accept_cycle, 1'b1);
      // Same burst without flush gives no send-immediate pulse
      clear_model();
      start_burst(8'hB0, 10, 1'b0);
      wait_idle(200);
      check_burst(8'hB0, 10);
      compare_word("siwua_count", siwua_count, 0);
   endtask

   task automatic test_busy_start_and_zero_len();
      clear_model();
      txe_mode = TXE_HOLD;
      start_burst(8'h30, 20, 1'b0);
      // FIFO fills and the counter stalls while txe is high
      repeat (20) @(negedge ft_clkout_i);
      check_reg(usb_stream_pkg::REG_STATUS, "status", 32'h1);
      start_burst(8'h80, 5, 1'b0);
      txe_mode = TXE_READY;
      wait_idle(200);
      check_burst(8'h30, 20);
      clear_model();
      start_burst(8'h55, 0, 1'b0);
      wait_idle(20);
      compare_word("rx_count", rx_q.size(), 0);
   endtask

   initial begin
      rst_n = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i = 1'b0;
      wb_adr_i = 2'd0;
      wb_dat_i = '0;
      ft_suspend_n_i = 1'b1;
      txe_mode = TXE_READY;
      cycle_count = 0;
      susp_prev = 1'b0;
      clear_model();
      repeat (4) @(negedge ft_clkout_i);
      rst_n = 1'b1;
      @(negedge ft_clkout_i);
      test_reset_and_regs();
      test_wrap_burst();
      test_random_txe_suspend();
      test_flush();
      test_busy_start_and_zero_len();
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- tx_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module tx_fifo (
   input  wire                                ft_clkout_i,
   input  wire                                rst_n,
   input  wire                                push_i,
   input  wire [usb_stream_pkg::DATA_W-1:0]   push_data_i,
   input  wire                                pop_i,
   output logic [usb_stream_pkg::DATA_W-1:0]  head_o,
   output logic                               empty_o,
   output logic                               full_o
);

   logic [usb_stream_pkg::DATA_W-1:0]  mem [usb_stream_pkg::FIFO_DEPTH];
   logic [usb_stream_pkg::FIFO_AW-1:0] wr_ptr_q;
   logic [usb_stream_pkg::FIFO_AW-1:0] rd_ptr_q;
   logic [usb_stream_pkg::FIFO_AW:0]   count_q;

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == usb_stream_pkg::FIFO_DEPTH);

   // First word fall through, head is the oldest entry
   assign head_o = mem[rd_ptr_q];

   always_ff @(posedge ft_clkout_i) begin
      if (push_i) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   // Pointers wrap at the power-of-two depth
   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Occupancy, unchanged on simultaneous push and pop
   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         count_q <= '0;
      end else begin
         case ({push_i, pop_i})
            2'b10: begin
               count_q <= count_q + 1'b1;
            end
            2'b01: begin
               count_q <= count_q - 1'b1;
            end
            default: begin
               count_q <= count_q;
            end
         endcase
      end
   end

   no_pop_when_empty: assert property (
      @(posedge ft_clkout_i) disable iff (!rst_n)
      pop_i |-> !empty_o
   );

   no_push_when_full: assert property (
      @(posedge ft_clkout_i) disable iff (!rst_n)
      push_i |-> !full_o
   );

endmodule

`default_nettype wire

//--- usb_stream_pkg.sv
`default_nettype none

package usb_stream_pkg;

   // USB byte and FIFO entry width
   localparam int DATA_W = 8;

   // Burst length and remaining count width
   localparam int LEN_W = 16;

   // Transmit FIFO geometry
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = 4;

   // Wishbone data width
   localparam int WB_DW = 32;

   // Word addresses of the register map
   typedef enum logic [1:0] {
      REG_CTRL   = 2'd0,
      REG_START  = 2'd1,
      REG_LEN    = 2'd2,
      REG_STATUS = 2'd3
   } wb_addr_e;

   // FT2232H writer states
   typedef enum logic [1:0] {
      TX_IDLE   = 2'd0,
      TX_STREAM = 2'd1,
      TX_FLUSH  = 2'd2
   } tx_state_e;

endpackage

`default_nettype wire

//--- usb_stream_top.sv
`default_nettype none
`timescale 1ns/10ps

module usb_stream_top (
   input  wire                                ft_clkout_i,
   input  wire                                rst_n,
   // Wishbone classic slave
   input  wire                                wb_cyc_i,
   input  wire                                wb_stb_i,
   input  wire                                wb_we_i,
   input  wire [1:0]                          wb_adr_i,
   input  wire [usb_stream_pkg::WB_DW-1:0]    wb_dat_i,
   output wire [usb_stream_pkg::WB_DW-1:0]    wb_dat_o,
   output wire                                wb_ack_o,
   // FT2232H write side, sync 245 FIFO mode
   output wire [usb_stream_pkg::DATA_W-1:0]   ft_data_o,
   output wire                                ft_wr_n_o,
   output wire                                ft_siwua_n_o,
   input  wire                                ft_txe_n_i,
   input  wire                                ft_suspend_n_i
);

   wire                                start;
   wire [usb_stream_pkg::DATA_W-1:0]   start_val;
   wire [usb_stream_pkg::LEN_W-1:0]    len;
   wire                                flush_en;
   wire                                busy;
   wire                                push;
   wire [usb_stream_pkg::DATA_W-1:0]   push_data;
   wire                                active;
   wire                                pop;
   wire                                empty;
   wire                                full;
   wire                                fsm_busy;

   // Busy until the source is done and the writer is back in idle
   assign busy = active | fsm_busy;

   wb_stream_regs u_regs (
      .ft_clkout_i (ft_clkout_i),
      .rst_n       (rst_n),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .busy_i      (busy),
      .start_o     (start),
      .start_val_o (start_val),
      .len_o       (len),
      .flush_en_o  (flush_en)
   );

   pattern_counter u_counter (
      .ft_clkout_i (ft_clkout_i),
      .rst_n       (rst_n),
      .start_i     (start),
      .start_val_i (start_val),
      .len_i       (len),
      .full_i      (full),
      .push_o      (push),
      .push_data_o (push_data),
      .active_o    (active)
   );

   // Head of the FIFO drives the USB data pins directly
   tx_fifo u_fifo (
      .ft_clkout_i (ft_clkout_i),
      .rst_n       (rst_n),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .head_o      (ft_data_o),
      .empty_o     (empty),
      .full_o      (full)
   );

   ft_tx_fsm u_fsm (
      .ft_clkout_i    (ft_clkout_i),
      .rst_n          (rst_n),
      .empty_i        (empty),
      .active_i       (active),
      .flush_en_i     (flush_en),
      .ft_txe_n_i     (ft_txe_n_i),
      .ft_suspend_n_i (ft_suspend_n_i),
      .pop_o          (pop),
      .ft_wr_n_o      (ft_wr_n_o),
      .ft_siwua_n_o   (ft_siwua_n_o),
      .busy_o         (fsm_busy)
   );

endmodule

`default_nettype wire

//--- wb_stream_regs.sv
`default_nettype none
`timescale 1ns/10ps

module wb_stream_regs (
   input  wire                                   ft_clkout_i,
   input  wire                                   rst_n,
   input  wire                                   wb_cyc_i,
   input  wire                                   wb_stb_i,
   input  wire                                   wb_we_i,
   input  wire [1:0]                             wb_adr_i,
   input  wire [usb_stream_pkg::WB_DW-1:0]       wb_dat_i,
   output logic [usb_stream_pkg::WB_DW-1:0]      wb_dat_o,
   output logic                                  wb_ack_o,
   input  wire                                   busy_i,
   output logic                                  start_o,
   output logic [usb_stream_pkg::DATA_W-1:0]     start_val_o,
   output logic [usb_stream_pkg::LEN_W-1:0]      len_o,
   output logic                                  flush_en_o
);

   usb_stream_pkg::wb_addr_e addr;
   logic                     req;
   logic                     wr_req;

   assign addr   = usb_stream_pkg::wb_addr_e'(wb_adr_i);
   // A new transfer needs ack low so the tail of the previous one is ignored
   assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
   assign wr_req = req && wb_we_i;

   // Ack and start pulse both land on the edge that accepts the request
   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         wb_ack_o <= 1'b0;
         start_o  <= 1'b0;
      end else begin
         wb_ack_o <= req;
         start_o  <= wr_req && (addr == usb_stream_pkg::REG_CTRL) &&
                     wb_dat_i[0] && !busy_i;
      end
   end

   // Writable registers
   always_ff @(posedge ft_clkout_i) begin
      if (!rst_n) begin
         start_val_o <= '0;
         len_o       <= '0;
         flush_en_o  <= 1'b0;
      end else if (wr_req) begin
         case (addr)
            usb_stream_pkg::REG_CTRL: begin
               flush_en_o <= wb_dat_i[1];
            end
            usb_stream_pkg::REG_START: begin
               start_val_o <= wb_dat_i[usb_stream_pkg::DATA_W-1:0];
            end
            usb_stream_pkg::REG_LEN: begin
               len_o <= wb_dat_i[usb_stream_pkg::LEN_W-1:0];
            end
            default: begin
               // STATUS is read-only
            end
         endcase
      end
   end

   // Read data is captured with the ack and held for its one cycle
   always_ff @(posedge ft_clkout_i) begin
      if (req && !wb_we_i) begin
         wb_dat_o <= '0;
         case (addr)
            usb_stream_pkg::REG_CTRL: begin
               // Start bit is a pulse and reads back as zero
               wb_dat_o[1] <= flush_en_o;
            end
            usb_stream_pkg::REG_START: begin
               wb_dat_o[usb_stream_pkg::DATA_W-1:0] <= start_val_o;
            end
            usb_stream_pkg::REG_LEN: begin
               wb_dat_o[usb_stream_pkg::LEN_W-1:0] <= len_o;
            end
            default: begin
               wb_dat_o[0] <= busy_i;
            end
         endcase
      end
   end

   // Start reaches the counter only while the whole path is idle
   start_pulse_while_idle: assert property (
      @(posedge ft_clkout_i) disable iff (!rst_n)
      start_o |-> !busy_i
   );

endmodule

`default_nettype wire
